//--- verilog/ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Data path width.
`define XLEN 32

// Architectural register file.
`define NUM_REGS 32
`define REG_W 5

// Reservation station size.
`define RS_ENTRIES 8

// Producer tags.
// Tag 0 means the value is present.
// Tag k names station entry k-1.
`define TAG_W 4

`endif

//--- verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    // Register-register layout, also used for shifts and LUI.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // Register-immediate layout.
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } insn_word_t;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        PASS_B = 4'd10  // LUI.
    } alu_op_t;

endpackage

`default_nettype wire

//--- verilog/insn_decode.sv
`default_nettype none

`include "ooo_defs.svh"

module insn_decode (
    input  wire ooo_pkg::insn_word_t insn,
    output logic                     legal,
    output ooo_pkg::alu_op_t         alu_op,
    output logic [`REG_W-1:0]        rd,
    output logic [`REG_W-1:0]        rs1,
    output logic [`REG_W-1:0]        rs2,
    output logic                     use_imm,
    output logic [`XLEN-1:0]         imm
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_sh;
    logic             is_shift;
    ooo_pkg::alu_op_t f3_op;

    assign imm_i    = {{(`XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};
    assign imm_u    = {insn.r.funct7, insn.r.rs2, insn.r.rs1, insn.r.funct3, 12'b0};
    assign imm_sh   = {{(`XLEN-5){1'b0}}, insn.r.rs2};  // Shamt sits in the rs2 field.
    assign is_shift = insn.r.funct3 == 3'b001 || insn.r.funct3 == 3'b101;

    // Same funct3 map for OP and OP-IMM; bit 30 picks SUB only for OP.
    always_comb begin
        case (insn.r.funct3)
            3'b000:  f3_op = (insn.r.opcode == OPC_OP && insn.r.funct7[5]) ?
                             ooo_pkg::SUB : ooo_pkg::ADD;
            3'b001:  f3_op = ooo_pkg::SLL;
            3'b010:  f3_op = ooo_pkg::SLT;
            3'b011:  f3_op = ooo_pkg::SLTU;
            3'b100:  f3_op = ooo_pkg::XOR;
            3'b101:  f3_op = insn.r.funct7[5] ? ooo_pkg::SRA : ooo_pkg::SRL;
            3'b110:  f3_op = ooo_pkg::OR;
            default: f3_op = ooo_pkg::AND;
        endcase
    end

    always_comb begin
        legal   = 1'b0;
        alu_op  = f3_op;
        use_imm = 1'b0;
        imm     = imm_i;
        rd      = insn.r.rd;
        rs1     = insn.r.rs1;
        rs2     = insn.r.rs2;
        case (insn.r.opcode)
            OPC_OP: begin
                legal = 1'b1;
            end
            OPC_OP_IMM: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                rs2     = '0;
                if (is_shift) imm = imm_sh;
            end
            OPC_LUI: begin
                legal   = 1'b1;
                alu_op  = ooo_pkg::PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
                rs1     = '0;  // Reads x0.
                rs2     = '0;
            end
            default: ;  // Dropped at dispatch.
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/rename_regfile.sv
`default_nettype none

`include "ooo_defs.svh"

module rename_regfile (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [`REG_W-1:0] rs1,
    input  wire logic [`REG_W-1:0] rs2,
    input  wire logic [`REG_W-1:0] rd,
    input  wire logic              alloc,
    input  wire logic [`TAG_W-1:0] alloc_tag,
    output logic [`TAG_W-1:0]      rs1_tag,
    output logic [`TAG_W-1:0]      rs2_tag,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  wire logic              cdb_fire,
    input  wire logic [`TAG_W-1:0] cdb_tag,
    input  wire logic [`REG_W-1:0] cdb_rd,
    input  wire logic [`XLEN-1:0]  cdb_data
);

    logic [`XLEN-1:0]  regs [`NUM_REGS];
    logic [`TAG_W-1:0] tags [`NUM_REGS];

    logic rs1_hit;
    logic rs2_hit;
    logic wb_match;

    // Same-cycle bypass from the broadcast.
    assign rs1_hit = cdb_fire && tags[rs1] != '0 && tags[rs1] == cdb_tag;
    assign rs2_hit = cdb_fire && tags[rs2] != '0 && tags[rs2] == cdb_tag;

    assign rs1_tag  = rs1_hit ? '0 : tags[rs1];
    assign rs2_tag  = rs2_hit ? '0 : tags[rs2];
    assign rs1_data = rs1_hit ? cdb_data : regs[rs1];
    assign rs2_data = rs2_hit ? cdb_data : regs[rs2];

    // A stale producer must not overwrite a newer value.
    assign wb_match = cdb_fire && cdb_rd != '0 && tags[cdb_rd] == cdb_tag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
                tags[k] <= '0;
            end
        end else begin
            if (wb_match) begin
                regs[cdb_rd] <= cdb_data;
                tags[cdb_rd] <= '0;
            end
            // New producer wins over a same-edge writeback.
            if (alloc && rd != '0) begin
                tags[rd] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/reservation_station.sv
`default_nettype none

`include "ooo_defs.svh"

module reservation_station (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              alloc,
    output logic [`TAG_W-1:0]      alloc_tag,
    output logic                   has_free,
    input  wire ooo_pkg::alu_op_t  alu_op,
    input  wire logic [`REG_W-1:0] rd,
    input  wire logic [`TAG_W-1:0] src1_tag,
    input  wire logic [`TAG_W-1:0] src2_tag,
    input  wire logic [`XLEN-1:0]  src1_data,
    input  wire logic [`XLEN-1:0]  src2_data,
    input  wire logic              use_imm,
    input  wire logic [`XLEN-1:0]  imm,
    input  wire logic              cdb_fire,
    input  wire logic [`TAG_W-1:0] cdb_tag,
    input  wire logic [`XLEN-1:0]  cdb_data,
    output logic                   issue_valid,
    input  wire logic              issue_ready,
    output ooo_pkg::alu_op_t       issue_op,
    output logic [`TAG_W-1:0]      issue_tag,
    output logic [`REG_W-1:0]      issue_rd,
    output logic [`XLEN-1:0]       issue_a,
    output logic [`XLEN-1:0]       issue_b
);

    localparam int IDX_W = $clog2(`RS_ENTRIES);

    logic [`RS_ENTRIES-1:0] occupied;
    logic [`RS_ENTRIES-1:0] issued;
    logic [`RS_ENTRIES-1:0] ready;
    logic [`RS_ENTRIES-1:0] wake1;
    logic [`RS_ENTRIES-1:0] wake2;
    logic [`RS_ENTRIES-1:0] retire;
    logic [`RS_ENTRIES-1:0] stale_issue;

    logic [`TAG_W-1:0] tag1  [`RS_ENTRIES];
    logic [`TAG_W-1:0] tag2  [`RS_ENTRIES];
    logic [`XLEN-1:0]  opnd1 [`RS_ENTRIES];
    logic [`XLEN-1:0]  opnd2 [`RS_ENTRIES];
    logic [`REG_W-1:0] rd_q  [`RS_ENTRIES];
    ooo_pkg::alu_op_t  op_q  [`RS_ENTRIES];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             issue_fire;

    always_comb begin
        for (int k = 0; k < `RS_ENTRIES; k++) begin
            ready[k]  = occupied[k] && !issued[k] && tag1[k] == '0 && tag2[k] == '0;
            wake1[k]  = cdb_fire && occupied[k] && tag1[k] != '0 && tag1[k] == cdb_tag;
            wake2[k]  = cdb_fire && occupied[k] && tag2[k] != '0 && tag2[k] == cdb_tag;
            retire[k] = cdb_fire && cdb_tag == `TAG_W'(k + 1);  // Own result broadcast.
            stale_issue[k] = issued[k] && (tag1[k] != '0 || tag2[k] != '0);
        end
    end

    // Lowest index wins for both allocation and issue.
    always_comb begin
        free_idx    = '0;
        has_free    = 1'b0;
        sel_idx     = '0;
        issue_valid = 1'b0;
        for (int k = `RS_ENTRIES - 1; k >= 0; k--) begin
            if (!occupied[k]) begin
                free_idx = IDX_W'(k);
                has_free = 1'b1;
            end
            if (ready[k]) begin
                sel_idx     = IDX_W'(k);
                issue_valid = 1'b1;
            end
        end
    end

    assign alloc_tag  = `TAG_W'(free_idx) + `TAG_W'(1);
    assign issue_tag  = `TAG_W'(sel_idx) + `TAG_W'(1);
    assign issue_op   = op_q[sel_idx];
    assign issue_rd   = rd_q[sel_idx];
    assign issue_a    = opnd1[sel_idx];
    assign issue_b    = opnd2[sel_idx];
    assign issue_fire = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
            issued   <= '0;
            for (int k = 0; k < `RS_ENTRIES; k++) begin
                tag1[k] <= '0;
                tag2[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `RS_ENTRIES; k++) begin
                if (retire[k]) begin
                    occupied[k] <= 1'b0;
                    issued[k]   <= 1'b0;
                end
                if (wake1[k]) tag1[k] <= '0;
                if (wake2[k]) tag2[k] <= '0;
                if (issue_fire && sel_idx == IDX_W'(k)) issued[k] <= 1'b1;
                if (alloc && free_idx == IDX_W'(k)) begin
                    occupied[k] <= 1'b1;
                    issued[k]   <= 1'b0;
                    tag1[k]     <= src1_tag;
                    tag2[k]     <= use_imm ? '0 : src2_tag;  // Immediate is present.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `RS_ENTRIES; k++) begin
            if (wake1[k]) opnd1[k] <= cdb_data;
            if (wake2[k]) opnd2[k] <= cdb_data;
            if (alloc && free_idx == IDX_W'(k)) begin
                opnd1[k] <= src1_data;
                opnd2[k] <= use_imm ? imm : src2_data;
                op_q[k]  <= alu_op;
                rd_q[k]  <= rd;
            end
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> has_free)
        else $error("Allocation while the station is full.");

    // Wakeup must have finished before an entry went to the ALU.
    a_issued_ready: assert property (@(posedge clk) disable iff (!rst_n)
        stale_issue == '0)
        else $error("Issued entry still waits on a tag.");

endmodule

`default_nettype wire

//--- verilog/int_alu.sv
`default_nettype none

`include "ooo_defs.svh"

module int_alu (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              issue_valid,
    output logic                   issue_ready,
    input  wire ooo_pkg::alu_op_t  issue_op,
    input  wire logic [`TAG_W-1:0] issue_tag,
    input  wire logic [`REG_W-1:0] issue_rd,
    input  wire logic [`XLEN-1:0]  issue_a,
    input  wire logic [`XLEN-1:0]  issue_b,
    output logic                   cdb_valid,
    output logic [`TAG_W-1:0]      cdb_tag,
    output logic [`REG_W-1:0]      cdb_rd,
    output logic [`XLEN-1:0]       cdb_data,
    input  wire logic              result_ready
);

    logic [`XLEN-1:0] alu_out;
    logic [4:0]       shamt;
    logic             take;

    assign shamt       = issue_b[4:0];
    assign issue_ready = !cdb_valid || result_ready;  // Empty or draining.
    assign take        = issue_valid && issue_ready;

    always_comb begin
        case (issue_op)
            ooo_pkg::ADD:    alu_out = issue_a + issue_b;
            ooo_pkg::SUB:    alu_out = issue_a - issue_b;
            ooo_pkg::AND:    alu_out = issue_a & issue_b;
            ooo_pkg::OR:     alu_out = issue_a | issue_b;
            ooo_pkg::XOR:    alu_out = issue_a ^ issue_b;
            ooo_pkg::SLL:    alu_out = issue_a << shamt;
            ooo_pkg::SRL:    alu_out = issue_a >> shamt;
            ooo_pkg::SRA:    alu_out = $signed(issue_a) >>> shamt;
            ooo_pkg::SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(issue_a) < $signed(issue_b)};
            ooo_pkg::SLTU:   alu_out = {{(`XLEN-1){1'b0}}, issue_a < issue_b};
            ooo_pkg::PASS_B: alu_out = issue_b;
            default:         alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else if (take) begin
            cdb_valid <= 1'b1;
        end else if (result_ready) begin
            cdb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cdb_tag  <= issue_tag;
            cdb_rd   <= issue_rd;
            cdb_data <= alu_out;
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cdb_valid && !result_ready |=> cdb_valid && $stable(cdb_tag) &&
        $stable(cdb_rd) && $stable(cdb_data))
        else $error("Result changed while stalled.");

endmodule

`default_nettype wire

//--- verilog/ooo_core.sv
`default_nettype none

`include "ooo_defs.svh"

module ooo_core (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              insn_valid,
    input  wire logic [31:0]       insn,
    output logic                   insn_ready,
    output logic                   result_valid,
    output logic [`REG_W-1:0]      result_rd,
    output logic [`XLEN-1:0]       result_data,
    input  wire logic              result_ready
);

    logic              legal;
    logic              use_imm;
    logic              alloc;
    logic              has_free;
    logic              cdb_fire;
    logic              cdb_valid;
    logic              issue_valid;
    logic              issue_ready;
    ooo_pkg::alu_op_t  dec_op;
    ooo_pkg::alu_op_t  issue_op;
    logic [`REG_W-1:0] dec_rd, dec_rs1, dec_rs2;
    logic [`REG_W-1:0] issue_rd, cdb_rd;
    logic [`XLEN-1:0]  dec_imm, rs1_data, rs2_data;
    logic [`XLEN-1:0]  issue_a, issue_b, cdb_data;
    logic [`TAG_W-1:0] alloc_tag, rs1_tag, rs2_tag;
    logic [`TAG_W-1:0] issue_tag, cdb_tag;

    assign alloc      = insn_valid && has_free && legal;  // Illegal words just drain.
    assign insn_ready = has_free;
    assign cdb_fire   = cdb_valid && result_ready;

    // The broadcast bus is the result port.
    assign result_valid = cdb_valid;
    assign result_rd    = cdb_rd;
    assign result_data  = cdb_data;

    insn_decode insn_decode_i (
        .insn(insn), .legal(legal), .alu_op(dec_op), .rd(dec_rd),
        .rs1(dec_rs1), .rs2(dec_rs2), .use_imm(use_imm), .imm(dec_imm)
    );

    rename_regfile rename_regfile_i (
        .clk(clk), .rst_n(rst_n), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .alloc(alloc), .alloc_tag(alloc_tag), .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .cdb_fire(cdb_fire),
        .cdb_tag(cdb_tag), .cdb_rd(cdb_rd), .cdb_data(cdb_data)
    );

    reservation_station reservation_station_i (
        .clk(clk), .rst_n(rst_n), .alloc(alloc), .alloc_tag(alloc_tag),
        .has_free(has_free), .alu_op(dec_op), .rd(dec_rd),
        .src1_tag(rs1_tag), .src2_tag(rs2_tag), .src1_data(rs1_data),
        .src2_data(rs2_data), .use_imm(use_imm), .imm(dec_imm),
        .cdb_fire(cdb_fire), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_op(issue_op),
        .issue_tag(issue_tag), .issue_rd(issue_rd), .issue_a(issue_a), .issue_b(issue_b)
    );

    int_alu int_alu_i (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .issue_op(issue_op), .issue_tag(issue_tag), .issue_rd(issue_rd),
        .issue_a(issue_a), .issue_b(issue_b), .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag), .cdb_rd(cdb_rd), .cdb_data(cdb_data),
        .result_ready(result_ready)
    );

endmodule

`default_nettype wire

//--- tests/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb;

    localparam int NUM_RANDOM = 200;
    localparam int NUM_INSNS  = NUM_RANDOM + 8;  // Random program plus x0..x7 readback.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        insn_valid;
    logic [31:0] insn;
    logic        insn_ready;
    logic        result_valid;
    logic [4:0]  result_rd;
    logic [31:0] result_data;
    logic        result_ready;

    logic [31:0] model_regs [32];
    logic [36:0] expected [$];  // Pending {rd, value} pairs.
    int          value_errors = 0;
    int          other_errors = 0;
    int          outstanding = 0;
    logic        saw_full = 1'b0;
    logic        held = 1'b0;
    logic [4:0]  held_rd;
    logic [31:0] held_data;

    ooo_core ooo_core_i (
        .clk(clk), .rst_n(rst_n), .insn_valid(insn_valid), .insn(insn),
        .insn_ready(insn_ready), .result_valid(result_valid), .result_rd(result_rd),
        .result_data(result_data), .result_ready(result_ready)
    );

    always #10 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
            value_errors++;
        end
    endtask

    function automatic logic is_supported(input logic [31:0] word);
        return word[6:0] == OPC_OP || word[6:0] == OPC_OP_IMM || word[6:0] == OPC_LUI;
    endfunction

    // Executes one word in program order. Returns {legal, rd, value}.
    function automatic logic [37:0] ref_exec(input logic [31:0] word);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        opc = word[6:0];
        rd  = word[11:7];
        a   = model_regs[word[19:15]];
        b   = (opc == OPC_OP) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        if (!is_supported(word)) return {1'b0, rd, 32'd0};
        case (word[14:12])
            3'b000:  res = (opc == OPC_OP && word[30]) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101: begin
                if (word[30]) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (opc == OPC_LUI) res = {word[31:12], 12'h000};
        if (rd != 5'd0) model_regs[rd] = res;
        return {1'b1, rd, res};
    endfunction

    // Half the words read the previous rd, so chains form often.
    function automatic logic [31:0] make_word(input logic [4:0] prev_rd);
        int          kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [31:0] word;
        kind = $urandom % 16;
        f3   = 3'($urandom);
        rd   = 5'($urandom % 8);
        rs1  = ($urandom % 2 != 0) ? prev_rd : 5'($urandom % 8);
        f7   = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 != 0) ? 7'h20 : 7'h00;
        if (kind < 7) begin
            word = {f7, 5'($urandom % 8), rs1, f3, rd, OPC_OP};
        end else if (kind < 13) begin
            if (f3 == 3'b001 || f3 == 3'b101) word = {f7, 5'($urandom), rs1, f3, rd, OPC_OP_IMM};
            else word = {12'($urandom), rs1, f3, rd, OPC_OP_IMM};
        end else if (kind < 15) begin
            word = {20'($urandom), rd, OPC_LUI};
        end else begin
            case ($urandom % 4)
                0:       opc = 7'b0000011;  // Load.
                1:       opc = 7'b0100011;  // Store.
                2:       opc = 7'b1100011;  // Branch.
                default: opc = 7'b1101111;
            endcase
            word = {25'($urandom), opc};
        end
        return word;
    endfunction

    task automatic send_word(input logic [31:0] word);
        if ($urandom % 8 == 0) begin
            @(negedge clk);
            insn_valid = 1'b0;
        end
        @(negedge clk);
        insn_valid = 1'b1;
        insn       = word;
        @(posedge clk);
        while (!insn_ready) @(posedge clk);
    endtask

    // Long stall first so the station fills, then random stretches.
    task automatic drive_ready();
        int len;
        bit level;
        repeat (24) @(negedge clk);
        forever begin
            len   = 1 + $urandom % 12;
            level = ($urandom % 3) != 0;
            repeat (len) begin
                @(negedge clk);
                result_ready = level;
            end
        end
    endtask

    task automatic take_result(input logic [4:0] rd, input logic [31:0] data);
        int hit;
        int same_rd;
        hit     = -1;
        same_rd = -1;
        foreach (expected[k]) begin
            if (hit < 0 && expected[k] == {rd, data}) hit = k;
            if (same_rd < 0 && expected[k][36:32] == rd) same_rd = k;
        end
        if (hit >= 0) begin
            expected.delete(hit);
        end else if (same_rd >= 0) begin
            compare_value("result_data", data, expected[same_rd][31:0]);
        end else begin
            $display("Result for x%0d at %0t has no pending instruction", rd, $time);
            other_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (held) begin
                compare_value("result_valid", result_valid, 1);
                compare_value("result_rd", result_rd, held_rd);
                compare_value("result_data", result_data, held_data);
            end
            compare_value("insn_ready", insn_ready, outstanding != 8);
            if (!insn_ready) saw_full = 1'b1;
            if (result_valid && result_ready) begin
                take_result(result_rd, result_data);
                outstanding--;
            end
            if (insn_valid && insn_ready && is_supported(insn)) outstanding++;
            held      = result_valid && !result_ready;
            held_rd   = result_rd;
            held_data = result_data;
        end
    end

    initial begin
        logic [31:0] word;
        logic [37:0] ref_out;
        logic [4:0]  prev_rd;
        void'($urandom(19));
        rst_n        = 1'b0;
        insn_valid   = 1'b0;
        insn         = '0;
        result_ready = 1'b0;
        prev_rd      = 5'd0;
        foreach (model_regs[k]) model_regs[k] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fork
            drive_ready();
        join_none
        for (int n = 0; n < NUM_INSNS; n++) begin
            if (n < NUM_RANDOM) word = make_word(prev_rd);
            else word = {12'd0, 5'(n - NUM_RANDOM), 3'b000, 5'(n - NUM_RANDOM), OPC_OP_IMM};
            prev_rd = word[11:7];
            ref_out = ref_exec(word);
            if (ref_out[37]) expected.push_back(ref_out[36:0]);
            send_word(word);
        end
        @(negedge clk);
        insn_valid = 1'b0;
        while (expected.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);  // Room for a stray result.
        compare_value("outstanding results", outstanding, 0);
        compare_value("result_valid after drain", result_valid, 0);
        compare_value("insn_ready after drain", insn_ready, 1);
        if (!saw_full) begin
            $display("insn_ready never dropped with eight instructions outstanding");
            other_errors++;
        end
        finish_run();
    end

    initial begin
        repeat (NUM_INSNS * 40 + 2000) @(posedge clk);
        $display("Timeout with %0d results still pending", expected.size());
        other_errors++;
        finish_run();
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verilog
verilog/ooo_pkg.sv
verilog/insn_decode.sv
verilog/rename_regfile.sv
verilog/reservation_station.sv
verilog/int_alu.sv
verilog/ooo_core.sv
tests/ooo_core_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module ooo_core_tb -o ooo_core_sim

run: compile
	@out="$$(./obj_dir/ooo_core_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
